// File: common/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 32;

    // exception flags carried with every fetched instruction
    localparam int EXC_NUM = 6;

    // bit positions inside exc_flags_t
    localparam int EXC_FLG_ADEF = 0;
    localparam int EXC_FLG_SYS  = 1;
    localparam int EXC_FLG_ALE  = 2;
    localparam int EXC_FLG_BRK  = 3;
    localparam int EXC_FLG_INE  = 4;
    localparam int EXC_FLG_INT  = 5;

    typedef logic [ADDR_W-1:0]  pc_t;
    typedef logic [DATA_W-1:0]  inst_t;
    typedef logic [EXC_NUM-1:0] exc_flags_t;

endpackage

`default_nettype wire

// File: common/fetch_cfg_pkg.sv
`default_nettype none

package fetch_cfg_pkg;

    // first fetch address after reset
    localparam cpu_bus_pkg::pc_t RESET_PC = 32'h1c00_0000;

    // entries between fetch and decode
    localparam int FQ_DEPTH = 4;

    typedef struct packed {
        cpu_bus_pkg::pc_t        pc;
        cpu_bus_pkg::inst_t      inst;
        cpu_bus_pkg::exc_flags_t flags;
    } fetch_entry_t;

endpackage

`default_nettype wire

// File: hw/pre_if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pre_if_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             fs_allowin,
    input  logic             fs_block,
    input  logic             br_taken,
    input  logic             br_stall,
    input  cpu_bus_pkg::pc_t br_target,
    input  logic             wb_exc,
    input  logic             wb_ertn,
    input  cpu_bus_pkg::pc_t eentry,
    input  cpu_bus_pkg::pc_t era,
    input  logic             inst_sram_addr_ok,
    output logic             inst_sram_req,
    output cpu_bus_pkg::pc_t inst_sram_addr,
    output logic             pfs_to_fs_valid,
    output cpu_bus_pkg::pc_t pfs_pc
);

    logic             req_r;
    cpu_bus_pkg::pc_t fetch_pc_r;
    logic             redirect;
    cpu_bus_pkg::pc_t redirect_pc;
    logic             req_accept;
    logic             issue_ok;

    // exception first, then return, then branch
    always_comb begin
        redirect    = wb_exc || wb_ertn || br_taken;
        redirect_pc = br_target;
        if (wb_exc) begin
            redirect_pc = eentry;
        end else if (wb_ertn) begin
            redirect_pc = era;
        end
    end

    assign req_accept = req_r && inst_sram_addr_ok;

    // fetch stage must be free and not waiting on data
    assign issue_ok = fs_allowin && !fs_block && !br_stall;

    // at most one request outstanding, so req drops on every accept
    always_ff @(posedge clk) begin
        if (reset) begin
            req_r <= 1'b0;
        end else if (req_accept) begin
            req_r <= 1'b0;
        end else if (issue_ok) begin
            req_r <= 1'b1;
        end
    end

    // address of the pending or next request
    // a redirect is kept here until its request goes out, and it also
    // retargets a request that is still waiting for addr_ok
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc_r <= fetch_cfg_pkg::RESET_PC;
        end else if (redirect) begin
            fetch_pc_r <= redirect_pc;
        end else if (req_accept) begin
            fetch_pc_r <= fetch_pc_r + 32'd4;
        end
    end

    assign inst_sram_req  = req_r;
    assign inst_sram_addr = fetch_pc_r;

    // handed over in the accept cycle
    assign pfs_to_fs_valid = req_accept;
    assign pfs_pc          = fetch_pc_r;

endmodule

`default_nettype wire

// File: hw/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pfs_to_fs_valid,
    input  cpu_bus_pkg::pc_t        pfs_pc,
    input  logic                    ds_allowin,
    input  logic                    br_taken_cancel,
    input  logic                    wb_exc,
    input  logic                    wb_ertn,
    input  logic                    inst_sram_data_ok,
    input  cpu_bus_pkg::inst_t      inst_sram_rdata,
    output logic                    fs_allowin,
    output logic                    fs_block,
    output logic                    fs_to_ds_valid,
    output cpu_bus_pkg::pc_t        fs_pc,
    output cpu_bus_pkg::inst_t      fs_inst,
    output cpu_bus_pkg::exc_flags_t fs_flags
);

    logic               fs_valid;
    cpu_bus_pkg::pc_t   fs_pc_r;
    logic               inst_buf_valid;
    cpu_bus_pkg::inst_t inst_buf;
    logic               cancel_r;
    logic [1:0]         drop_cnt;
    logic               cancel_now;
    logic               fs_kill;
    logic               data_ok_live;
    logic               data_ok_stale;
    logic               drop_inc;
    logic               fs_ready_go;
    logic               fs_accept;
    logic               buf_load;

    assign cancel_now = wb_exc || wb_ertn || br_taken_cancel;
    assign fs_kill    = cancel_now || cancel_r;

    // data_ok pulses owed to dropped instructions come first
    assign data_ok_stale = inst_sram_data_ok && (drop_cnt != 2'd0);
    assign data_ok_live  = inst_sram_data_ok && (drop_cnt == 2'd0);

    assign fs_ready_go    = inst_buf_valid || (fs_valid && data_ok_live);
    assign fs_allowin     = !fs_valid || fs_kill || (fs_ready_go && ds_allowin);
    assign fs_to_ds_valid = fs_valid && fs_ready_go && !fs_kill;
    assign fs_accept      = pfs_to_fs_valid && fs_allowin;

    // no new request while data is still owed to this stage
    assign fs_block = (fs_valid && !fs_ready_go) || (drop_cnt != 2'd0);

    // killed while its data is still on the way
    assign drop_inc = fs_valid && fs_kill && !inst_buf_valid && !data_ok_live;

    assign buf_load = fs_valid && data_ok_live && !inst_buf_valid && !fs_kill && !ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= pfs_to_fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_accept) begin
            fs_pc_r <= pfs_pc;
        end
    end

    // a request accepted in the redirect cycle is still old path,
    // so the cancel holds until the next accepted pc
    always_ff @(posedge clk) begin
        if (reset) begin
            cancel_r <= 1'b0;
        end else if (cancel_now) begin
            cancel_r <= 1'b1;
        end else if (fs_accept) begin
            cancel_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            drop_cnt <= 2'd0;
        end else begin
            drop_cnt <= drop_cnt + {1'b0, drop_inc} - {1'b0, data_ok_stale};
        end
    end

    // one word holds the instruction while decode stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            inst_buf_valid <= 1'b0;
        end else if (buf_load) begin
            inst_buf_valid <= 1'b1;
        end else if (ds_allowin || fs_kill) begin
            inst_buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_load) begin
            inst_buf <= inst_sram_rdata;
        end
    end

    assign fs_pc   = fs_pc_r;
    assign fs_inst = inst_buf_valid ? inst_buf : inst_sram_rdata;

    always_comb begin
        fs_flags[cpu_bus_pkg::EXC_FLG_ADEF] = |fs_pc_r[1:0];
        // raised by later stages, never here
        fs_flags[cpu_bus_pkg::EXC_FLG_SYS]  = 1'b0;
        fs_flags[cpu_bus_pkg::EXC_FLG_ALE]  = 1'b0;
        fs_flags[cpu_bus_pkg::EXC_FLG_BRK]  = 1'b0;
        fs_flags[cpu_bus_pkg::EXC_FLG_INE]  = 1'b0;
        fs_flags[cpu_bus_pkg::EXC_FLG_INT]  = 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_allowin,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_allowin
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign in_allowin = (count != CNT_W'(DEPTH));
    assign out_valid  = (count != '0);

    // head entry read straight from the storage flops
    assign out_data = mem[rd_ptr];

    assign push = in_valid && in_allowin;
    assign pop  = out_valid && out_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ds_allowin,
    input  logic                    br_taken,
    input  logic                    br_taken_cancel,
    input  logic                    br_stall,
    input  cpu_bus_pkg::pc_t        br_target,
    input  logic                    wb_exc,
    input  logic                    wb_ertn,
    input  cpu_bus_pkg::pc_t        eentry,
    input  cpu_bus_pkg::pc_t        era,
    output logic                    inst_sram_req,
    output cpu_bus_pkg::pc_t        inst_sram_addr,
    input  logic                    inst_sram_addr_ok,
    input  logic                    inst_sram_data_ok,
    input  cpu_bus_pkg::inst_t      inst_sram_rdata,
    output logic                    ds_valid,
    output cpu_bus_pkg::pc_t        ds_pc,
    output cpu_bus_pkg::inst_t      ds_inst,
    output cpu_bus_pkg::exc_flags_t ds_flags
);

    logic                        pfs_to_fs_valid;
    cpu_bus_pkg::pc_t            pfs_pc;
    logic                        fs_allowin;
    logic                        fs_block;
    logic                        fs_to_ds_valid;
    cpu_bus_pkg::pc_t            fs_pc;
    cpu_bus_pkg::inst_t          fs_inst;
    cpu_bus_pkg::exc_flags_t     fs_flags;
    logic                        fq_allowin;
    fetch_cfg_pkg::fetch_entry_t fq_in;
    fetch_cfg_pkg::fetch_entry_t fq_out;

    pre_if_stage u_pre_if_stage (
        .clk               (clk),
        .reset             (reset),
        .fs_allowin        (fs_allowin),
        .fs_block          (fs_block),
        .br_taken          (br_taken),
        .br_stall          (br_stall),
        .br_target         (br_target),
        .wb_exc            (wb_exc),
        .wb_ertn           (wb_ertn),
        .eentry            (eentry),
        .era               (era),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .pfs_to_fs_valid   (pfs_to_fs_valid),
        .pfs_pc            (pfs_pc)
    );

    if_stage u_if_stage (
        .clk               (clk),
        .reset             (reset),
        .pfs_to_fs_valid   (pfs_to_fs_valid),
        .pfs_pc            (pfs_pc),
        .ds_allowin        (fq_allowin),
        .br_taken_cancel   (br_taken_cancel),
        .wb_exc            (wb_exc),
        .wb_ertn           (wb_ertn),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .fs_allowin        (fs_allowin),
        .fs_block          (fs_block),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_pc             (fs_pc),
        .fs_inst           (fs_inst),
        .fs_flags          (fs_flags)
    );

    assign fq_in.pc    = fs_pc;
    assign fq_in.inst  = fs_inst;
    assign fq_in.flags = fs_flags;

    fetch_queue #(
        .payload_t (fetch_cfg_pkg::fetch_entry_t),
        .DEPTH     (fetch_cfg_pkg::FQ_DEPTH)
    ) u_fetch_queue (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (fs_to_ds_valid),
        .in_data     (fq_in),
        .in_allowin  (fq_allowin),
        .out_valid   (ds_valid),
        .out_data    (fq_out),
        .out_allowin (ds_allowin)
    );

    assign ds_pc    = fq_out.pc;
    assign ds_inst  = fq_out.inst;
    assign ds_flags = fq_out.flags;

endmodule

`default_nettype wire

// File: sim/inst_sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module inst_sram_model #(
    parameter int SEED = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  cpu_bus_pkg::pc_t   addr,
    output logic               addr_ok,
    output logic               data_ok,
    output cpu_bus_pkg::inst_t rdata
);

    int                 seed;
    int                 addr_wait;
    int                 data_wait;
    logic               busy;
    cpu_bus_pkg::pc_t   data_addr;
    logic               next_addr_ok;
    logic               next_data_ok;
    cpu_bus_pkg::inst_t next_rdata;

    // contents are a fixed mix of the whole address
    function automatic cpu_bus_pkg::inst_t word_at(input cpu_bus_pkg::pc_t a);
        return (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};
    endfunction

    initial begin
        seed      = SEED;
        addr_wait = $unsigned($random(seed)) % 3;
        data_wait = 0;
        busy      = 1'b0;
        data_addr = '0;
        addr_ok   = 1'b0;
        data_ok   = 1'b0;
        rdata     = '0;
        forever begin
            // next cycle decided mid cycle, driven just after the edge
            @(negedge clk);
            next_addr_ok = 1'b0;
            next_data_ok = 1'b0;
            next_rdata   = rdata;
            if (reset) begin
                busy = 1'b0;
            end else if (busy) begin
                if (data_wait == 0) begin
                    next_data_ok = 1'b1;
                    next_rdata   = word_at(data_addr);
                    busy         = 1'b0;
                end else begin
                    data_wait = data_wait - 1;
                end
            end else if (req && addr_ok) begin
                // accepted at the coming edge
                data_addr = addr;
                data_wait = $unsigned($random(seed)) % 3;
                addr_wait = $unsigned($random(seed)) % 3;
                if (data_wait == 0) begin
                    next_data_ok = 1'b1;
                    next_rdata   = word_at(addr);
                end else begin
                    busy      = 1'b1;
                    data_wait = data_wait - 1;
                end
            end else if (req) begin
                if (addr_wait == 0) begin
                    next_addr_ok = 1'b1;
                end else begin
                    addr_wait = addr_wait - 1;
                end
            end
            @(posedge clk);
            #2;
            addr_ok = next_addr_ok;
            data_ok = next_data_ok;
            rdata   = next_rdata;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

    localparam int REDIR_BR   = 0;
    localparam int REDIR_EXC  = 1;
    localparam int REDIR_ERTN = 2;
    localparam int WAIT_LIMIT = 1000;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    ds_allowin;
    logic                    br_taken;
    logic                    br_taken_cancel;
    logic                    br_stall;
    cpu_bus_pkg::pc_t        br_target;
    logic                    wb_exc;
    logic                    wb_ertn;
    cpu_bus_pkg::pc_t        eentry;
    cpu_bus_pkg::pc_t        era;
    logic                    inst_sram_req;
    cpu_bus_pkg::pc_t        inst_sram_addr;
    logic                    inst_sram_addr_ok;
    logic                    inst_sram_data_ok;
    cpu_bus_pkg::inst_t      inst_sram_rdata;
    logic                    ds_valid;
    cpu_bus_pkg::pc_t        ds_pc;
    cpu_bus_pkg::inst_t      ds_inst;
    cpu_bus_pkg::exc_flags_t ds_flags;

    int                      seed;
    int                      delivered;
    int                      redirect_count;
    int                      applied_count;
    cpu_bus_pkg::pc_t        redirect_pc;
    cpu_bus_pkg::pc_t        exp_pc;

    always #20 clk = ~clk;

    fetch_top u_dut (.*);

    inst_sram_model #(.SEED(32'h4187_28ca)) u_sram (
        .clk     (clk),
        .reset   (reset),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    function automatic cpu_bus_pkg::inst_t model_inst(input cpu_bus_pkg::pc_t pc);
        return (pc * 32'h9e37_79b1) ^ {pc[7:0], pc[31:8]};
    endfunction

    // fetch address error is the only flag the front end raises
    function automatic fetch_cfg_pkg::fetch_entry_t expected_entry(
        input cpu_bus_pkg::pc_t pc
    );
        fetch_cfg_pkg::fetch_entry_t e;
        e.pc    = pc;
        e.inst  = model_inst(pc);
        e.flags = '0;
        e.flags[cpu_bus_pkg::EXC_FLG_ADEF] = |pc[1:0];
        return e;
    endfunction

    task automatic fail_and_stop();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_pc(input string name, input cpu_bus_pkg::pc_t got,
                            input cpu_bus_pkg::pc_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_inst(input string name, input cpu_bus_pkg::inst_t got,
                              input cpu_bus_pkg::inst_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_flags(input string name, input cpu_bus_pkg::exc_flags_t got,
                               input cpu_bus_pkg::exc_flags_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_entry(input fetch_cfg_pkg::fetch_entry_t got,
                               input fetch_cfg_pkg::fetch_entry_t exp);
        check_pc("ds_pc", got.pc, exp.pc);
        check_inst("ds_inst", got.inst, exp.inst);
        check_flags("ds_flags", got.flags, exp.flags);
    endtask

    // one transfer on every cycle with ds_valid and ds_allowin high
    always @(negedge clk) begin
        fetch_cfg_pkg::fetch_entry_t got;
        if (reset) begin
            exp_pc        = fetch_cfg_pkg::RESET_PC;
            applied_count = 0;
            delivered     = 0;
        end else begin
            if (applied_count != redirect_count) begin
                exp_pc        = redirect_pc;
                applied_count = redirect_count;
            end
            if (ds_valid && ds_allowin) begin
                got.pc    = ds_pc;
                got.inst  = ds_inst;
                got.flags = ds_flags;
                check_entry(got, expected_entry(exp_pc));
                exp_pc    = exp_pc + 32'd4;
                delivered = delivered + 1;
            end
        end
    end

    task automatic wait_delivered(input int count, input logic random_allowin);
        int target;
        int cycles;
        int rnd;
        target = delivered + count;
        cycles = 0;
        while (delivered < target) begin
            @(posedge clk);
            #2;
            if (random_allowin) begin
                rnd        = $random(seed);
                ds_allowin = rnd[0];
            end
            cycles = cycles + 1;
            if (cycles > WAIT_LIMIT) begin
                $display("no instruction delivered before timeout");
                fail_and_stop();
            end
        end
        ds_allowin = 1'b1;
    endtask

    // nothing from the old path may still be in flight
    task automatic drain_queue();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 8) begin
            @(negedge clk);
            if (ds_valid) begin
                quiet = 0;
            end else begin
                quiet = quiet + 1;
            end
            cycles = cycles + 1;
            if (cycles > WAIT_LIMIT) begin
                $display("fetch queue did not drain before timeout");
                fail_and_stop();
            end
        end
    endtask

    task automatic redirect_to(input int kind, input cpu_bus_pkg::pc_t target);
        @(posedge clk);
        #2;
        br_stall   = 1'b1;
        ds_allowin = 1'b1;
        drain_queue();
        @(posedge clk);
        #2;
        case (kind)
            REDIR_BR: begin
                br_taken        = 1'b1;
                br_taken_cancel = 1'b1;
                br_target       = target;
            end
            REDIR_EXC: begin
                wb_exc = 1'b1;
                eentry = target;
            end
            REDIR_ERTN: begin
                wb_ertn = 1'b1;
                era     = target;
            end
            default: begin
            end
        endcase
        br_stall       = 1'b0;
        redirect_pc    = target;
        redirect_count = redirect_count + 1;
        @(posedge clk);
        #2;
        br_taken        = 1'b0;
        br_taken_cancel = 1'b0;
        wb_exc          = 1'b0;
        wb_ertn         = 1'b0;
    endtask

    initial begin
        seed            = 32'h4187_28ca;
        redirect_count  = 0;
        redirect_pc     = '0;
        reset           = 1'b1;
        ds_allowin      = 1'b0;
        br_taken        = 1'b0;
        br_taken_cancel = 1'b0;
        br_stall        = 1'b0;
        br_target       = '0;
        wb_exc          = 1'b0;
        wb_ertn         = 1'b0;
        eentry          = '0;
        era             = '0;
        @(posedge clk);
        @(negedge clk);
        check_bit("inst_sram_req", inst_sram_req, 1'b0);
        check_bit("ds_valid", ds_valid, 1'b0);
        repeat (2) @(posedge clk);
        #2;
        reset      = 1'b0;
        ds_allowin = 1'b1;
        // first request goes out right after reset
        @(posedge clk);
        @(negedge clk);
        check_bit("inst_sram_req", inst_sram_req, 1'b1);
        check_pc("inst_sram_addr", inst_sram_addr, fetch_cfg_pkg::RESET_PC);
        wait_delivered(32, 1'b0);
        // let the queue fill up under back-pressure
        ds_allowin = 1'b0;
        repeat (20) @(posedge clk);
        wait_delivered(64, 1'b1);
        redirect_to(REDIR_BR, 32'h1c00_4000);
        wait_delivered(16, 1'b0);
        redirect_to(REDIR_EXC, 32'h1c00_8000);
        wait_delivered(16, 1'b1);
        redirect_to(REDIR_ERTN, 32'h1c00_0100);
        wait_delivered(16, 1'b0);
        // misaligned target carries ADEF
        redirect_to(REDIR_BR, 32'h1c00_6002);
        wait_delivered(4, 1'b0);
        redirect_to(REDIR_BR, 32'h1c00_0200);
        wait_delivered(8, 1'b1);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/cpu_bus_pkg.sv
common/fetch_cfg_pkg.sv
hw/pre_if_stage.sv
hw/if_stage.sv
hw/fetch_queue.sv
hw/fetch_top.sv
sim/inst_sram_model.sv
sim/tb_fetch_top.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch front end testbench with Verilator and run it
# the simulator exit status is the verdict
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_fetch_top \
    -f filelist.f \
    --Mdir obj_dir -o tb_fetch_top_sim
./obj_dir/tb_fetch_top_sim
